//--- verilog/residueParams.svh
`ifndef RESIDUE_PARAMS_SVH
`define RESIDUE_PARAMS_SVH

// Filter order M, taps a[0] up to a[M]
`define RESIDUE_ORDER 4'd10

// Shared word memory geometry
`define MEM_ADDR_BITS 12
`define MEM_DEPTH 4096

// Width of the output count LG
`define LG_BITS 6

`endif

//--- verilog/basicOpPkg.sv
package basicOpPkg;

	// Q15 sample and Q31 accumulator words
	typedef logic signed [15:0] word16;
	typedef logic signed [31:0] word32;

	// Inputs of the combinational operator block
	typedef struct packed {
		word16 opA;
		word16 opB;
		word32 accIn;
		word32 roundIn;
	} macOperands;

	// L_mult, L_mac and rounding L_add results
	typedef struct packed {
		word32 product;
		word32 macSum;
		word32 rounded;
	} macResults;

	// Long shift job, held while ready is high
	typedef struct packed {
		logic ready;
		word32 value;
		logic [3:0] count;
	} shiftRequest;

	typedef struct packed {
		logic done;
		word32 value;
	} shiftResponse;

endpackage

//--- verilog/residueMemPkg.sv
`include "residueParams.svh"

package residueMemPkg;

	typedef logic [`MEM_ADDR_BITS-1:0] memAddr;

	// Coefficient port and sample port addresses
	typedef struct packed {
		memAddr addrA;
		memAddr addrX;
	} memReadReq;

	// Registered read data, one cycle after the address
	typedef struct packed {
		logic [31:0] dataA;
		logic [31:0] dataX;
	} memReadData;

	// Single word write, shared by filter and host
	typedef struct packed {
		logic en;
		memAddr addr;
		logic [31:0] data;
	} memWrite;

endpackage

//--- verilog/basicOps.sv
module basicOps (
	input basicOpPkg::macOperands operands,
	output basicOpPkg::macResults results
);
	import basicOpPkg::*;

	localparam word16 MIN_WORD16 = 16'sh8000;
	localparam word32 MAX_WORD32 = 32'sh7FFFFFFF;
	localparam word32 MIN_WORD32 = 32'sh80000000;
	localparam word32 ROUND_HALF = 32'sh00008000;

	////////////////////
	// Saturating operators
	////////////////////

	// 32-bit add, clamped on signed overflow
	function automatic word32 satAdd(input word32 a, input word32 b);
		word32 sum;
		sum = a + b;
		if (a[31] == b[31] && sum[31] != a[31])
		begin
			if (a[31])
				return MIN_WORD32;
			else
				return MAX_WORD32;
		end
		return sum;
	endfunction

	// Doubled product, the fractional Q15 by Q15 multiply
	function automatic word32 multDouble(input word16 a, input word16 b);
		word32 prod;
		prod = a * b;
		// Only -1 times -1 leaves the Q31 range
		if (a == MIN_WORD16 && b == MIN_WORD16)
			return MAX_WORD32;
		return prod <<< 1;
	endfunction

	////////////////////
	// Operator outputs
	////////////////////

	word32 product;
	word32 macSum;
	word32 rounded;

	always_comb
	begin
		product = multDouble(operands.opA, operands.opB);
		// L_mac is L_mult followed by L_add
		macSum = satAdd(operands.accIn, product);
		// Round to the upper half word
		rounded = satAdd(operands.roundIn, ROUND_HALF);
	end

	always_comb
	begin
		results.product = product;
		results.macSum = macSum;
		results.rounded = rounded;
	end

endmodule

//--- verilog/longShifter.sv
module longShifter (
	input logic clk,
	input logic reset,
	input basicOpPkg::shiftRequest request,
	output basicOpPkg::shiftResponse response
);
	import basicOpPkg::*;

	logic busy;
	word32 value;
	logic [3:0] remaining;

	// One saturating left shift by a single bit
	function automatic word32 doubleSat(input word32 v);
		if (v[31] != v[30])
		begin
			if (v[31])
				return 32'sh80000000;
			else
				return 32'sh7FFFFFFF;
		end
		return v <<< 1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
			busy <= 1'b0;
		else if (!busy)
			busy <= request.ready;
		else if (remaining == 4'd0)
			busy <= 1'b0;
	end

	// First shift happens on load so done lands count cycles after ready
	always_ff @(posedge clk)
	begin
		if (!busy && request.ready)
		begin
			if (request.count == 4'd0)
			begin
				value <= request.value;
				remaining <= 4'd0;
			end
			else
			begin
				value <= doubleSat(request.value);
				remaining <= request.count - 4'd1;
			end
		end
		else if (busy && remaining != 4'd0)
		begin
			value <= doubleSat(value);
			remaining <= remaining - 4'd1;
		end
	end

	always_comb
	begin
		response.done = busy && remaining == 4'd0;
		response.value = value;
	end

endmodule

//--- verilog/sampleMemory.sv
`include "residueParams.svh"

module sampleMemory (
	input logic clk,
	input residueMemPkg::memReadReq readReq,
	output residueMemPkg::memReadData readData,
	input residueMemPkg::memWrite filterWrite,
	input residueMemPkg::memWrite hostWrite,
	input residueMemPkg::memAddr hostReadAddr,
	output logic [31:0] hostReadData
);

	logic [31:0] words [`MEM_DEPTH];
	logic hostCollides;

	// Host and filter writing the same word in one cycle
	assign hostCollides = hostWrite.en && (hostWrite.addr == filterWrite.addr);

	////////////////////
	// Write ports
	////////////////////

	always_ff @(posedge clk)
	begin
		if (filterWrite.en && !hostCollides)
			words[filterWrite.addr] <= filterWrite.data;
		if (hostWrite.en)
			words[hostWrite.addr] <= hostWrite.data;
	end

	////////////////////
	// Read ports
	////////////////////

	// All three reads return the old word on a same-cycle write
	always_ff @(posedge clk)
	begin
		readData.dataA <= words[readReq.addrA];
		readData.dataX <= words[readReq.addrX];
		hostReadData <= words[hostReadAddr];
	end

endmodule

//--- verilog/residueFilter.sv
`include "residueParams.svh"

module residueFilter (
	input logic clk,
	input logic reset,
	input logic start,
	input residueMemPkg::memAddr A,
	input residueMemPkg::memAddr X,
	input residueMemPkg::memAddr Y,
	input logic [`LG_BITS-1:0] LG,
	input logic [3:0] scaleShift,
	output logic done,
	output residueMemPkg::memReadReq readReq,
	input residueMemPkg::memReadData readData,
	output residueMemPkg::memWrite memWriteOut,
	output basicOpPkg::macOperands opOperands,
	input basicOpPkg::macResults opResults,
	output basicOpPkg::shiftRequest shiftReq,
	input basicOpPkg::shiftResponse shiftResp
);
	import basicOpPkg::*;
	import residueMemPkg::*;

	typedef enum logic [3:0] {
		INIT,
		FOR1,
		MEM1,
		LMULT,
		FOR2,
		MEM2,
		LMAC,
		LSHL,
		ROUND,
		INC,
		DONE
	} filterState;

	filterState state;
	filterState nextState;

	// Outer loop over outputs, inner loop over taps
	logic [`LG_BITS-1:0] I;
	logic [3:0] J;

	// Holds x[i] before LMULT and a[j] before each LMAC
	word16 sampleReg;
	word32 S;

	////////////////////
	// Control registers
	////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= INIT;
			I <= '0;
			J <= 4'd1;
		end
		else
		begin
			state <= nextState;
			case (state)
				INIT:
					I <= '0;
				LMULT:
					J <= 4'd1;
				LMAC:
					J <= J + 4'd1;
				INC:
					I <= I + 1'b1;
				default:
					J <= J;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk)
	begin
		case (state)
			MEM1:
				sampleReg <= readData.dataX[15:0];
			MEM2:
				sampleReg <= readData.dataA[15:0];
			LMULT:
				S <= opResults.product;
			LMAC:
				S <= opResults.macSum;
			LSHL:
				if (shiftResp.done)
					S <= shiftResp.value;
			default:
				S <= S;
		endcase
	end

	////////////////////
	// FSM outputs
	////////////////////

	always_comb
	begin
		nextState = state;
		done = 1'b0;
		readReq = '0;
		memWriteOut = '0;
		opOperands = '0;
		shiftReq = '0;

		case (state)
			INIT:
				if (start)
					nextState = FOR1;

			FOR1:
				if (I < LG)
				begin
					readReq.addrX = X + memAddr'(I);
					nextState = MEM1;
				end
				else
					nextState = DONE;

			MEM1:
			begin
				readReq.addrA = A;
				nextState = LMULT;
			end

			// a[0] * x[i] starts the sum
			LMULT:
			begin
				opOperands.opA = sampleReg;
				opOperands.opB = readData.dataA[15:0];
				nextState = FOR2;
			end

			FOR2:
				if (J <= `RESIDUE_ORDER)
				begin
					readReq.addrA = A + memAddr'(J);
					nextState = MEM2;
				end
				else
				begin
					// Shift job goes out on the same cycle the loop ends
					shiftReq.ready = 1'b1;
					shiftReq.value = S;
					shiftReq.count = scaleShift;
					nextState = LSHL;
				end

			// History samples sit below X
			MEM2:
			begin
				readReq.addrX = X + memAddr'(I) - memAddr'(J);
				nextState = LMAC;
			end

			LMAC:
			begin
				opOperands.opA = sampleReg;
				opOperands.opB = readData.dataX[15:0];
				opOperands.accIn = S;
				nextState = FOR2;
			end

			LSHL:
			begin
				shiftReq.value = S;
				shiftReq.count = scaleShift;
				shiftReq.ready = !shiftResp.done;
				if (shiftResp.done)
					nextState = ROUND;
			end

			ROUND:
			begin
				opOperands.roundIn = S;
				memWriteOut.en = 1'b1;
				memWriteOut.addr = Y + memAddr'(I);
				memWriteOut.data = {{16{opResults.rounded[31]}}, opResults.rounded[31:16]};
				nextState = INC;
			end

			INC:
				nextState = FOR1;

			DONE:
			begin
				done = 1'b1;
				nextState = INIT;
			end

			default:
				nextState = INIT;
		endcase
	end

endmodule

//--- verilog/residueTop.sv
`include "residueParams.svh"

module residueTop (
	input logic clk,
	input logic reset,
	input logic start,
	input residueMemPkg::memAddr A,
	input residueMemPkg::memAddr X,
	input residueMemPkg::memAddr Y,
	input logic [`LG_BITS-1:0] LG,
	input logic [3:0] scaleShift,
	output logic done,
	input residueMemPkg::memWrite hostWrite,
	input residueMemPkg::memAddr hostReadAddr,
	output logic [31:0] hostReadData
);
	import basicOpPkg::*;
	import residueMemPkg::*;

	// Filter to memory
	memReadReq readReq;
	memReadData readData;
	memWrite filterWrite;

	// Filter to operators
	macOperands opOperands;
	macResults opResults;
	shiftRequest shiftReq;
	shiftResponse shiftResp;

	residueFilter filter (
		.clk(clk),
		.reset(reset),
		.start(start),
		.A(A),
		.X(X),
		.Y(Y),
		.LG(LG),
		.scaleShift(scaleShift),
		.done(done),
		.readReq(readReq),
		.readData(readData),
		.memWriteOut(filterWrite),
		.opOperands(opOperands),
		.opResults(opResults),
		.shiftReq(shiftReq),
		.shiftResp(shiftResp)
	);

	basicOps ops (
		.operands(opOperands),
		.results(opResults)
	);

	longShifter shifter (
		.clk(clk),
		.reset(reset),
		.request(shiftReq),
		.response(shiftResp)
	);

	sampleMemory memory (
		.clk(clk),
		.readReq(readReq),
		.readData(readData),
		.filterWrite(filterWrite),
		.hostWrite(hostWrite),
		.hostReadAddr(hostReadAddr),
		.hostReadData(hostReadData)
	);

endmodule

//--- test/residueProps.sv
`include "residueParams.svh"

module residueProps (
	input logic clk,
	input logic reset,
	input logic start,
	input logic done,
	input residueMemPkg::memAddr A,
	input residueMemPkg::memAddr X,
	input residueMemPkg::memAddr Y,
	input logic [`LG_BITS-1:0] LG,
	input logic [3:0] scaleShift,
	input residueMemPkg::memWrite filterWrite,
	input residueMemPkg::memWrite hostWrite,
	input residueMemPkg::memAddr hostReadAddr,
	input logic [31:0] hostReadData,
	input basicOpPkg::shiftRequest shiftReq,
	input basicOpPkg::shiftResponse shiftResp
);
	import basicOpPkg::*;
	import residueMemPkg::*;

	int unsigned failCount = 0;

	logic [31:0] shadow [`MEM_DEPTH];
	logic [31:0] hostExpect;
	logic [31:0] expectedY;
	logic running;
	logic [`LG_BITS:0] writeCount;
	logic shiftPending;
	logic [4:0] shiftCycles;
	logic [4:0] shiftTarget;
	word32 shiftExpect;

	////////////////////
	// Golden arithmetic
	////////////////////

	function automatic word32 clamp32(input longint v);
		if (v > 64'sd2147483647)
			return 32'sh7FFFFFFF;
		if (v < -64'sd2147483648)
			return 32'sh80000000;
		return v[31:0];
	endfunction

	// Fractional multiply saturated on its own before any add
	function automatic word32 fracMult(input word16 a, input word16 b);
		return clamp32(2 * longint'(a) * longint'(b));
	endfunction

	function automatic word32 shlSat(input word32 v, input logic [3:0] n);
		word32 s;
		s = v;
		for (int k = 0; k < n; k++)
			s = clamp32(2 * longint'(s));
		return s;
	endfunction

	function automatic word16 wordAt(input memAddr addr);
		return word16'(shadow[addr][15:0]);
	endfunction

	function automatic logic [31:0] residueAt(input memAddr i);
		word32 s;
		word32 r;
		s = fracMult(wordAt(A), wordAt(memAddr'(X + i)));
		for (int j = 1; j <= `RESIDUE_ORDER; j++)
			s = clamp32(longint'(s) + longint'(fracMult(wordAt(memAddr'(A + j)),
				wordAt(memAddr'(X + i - j)))));
		s = shlSat(s, scaleShift);
		r = clamp32(longint'(s) + 64'sd32768);
		return {{16{r[31]}}, r[31:16]};
	endfunction

	always_comb
	begin
		expectedY = residueAt(memAddr'(filterWrite.addr - Y));
	end

	////////////////////
	// Shadow state
	////////////////////

	// Host write wins on a shared address and reads see the old word
	always_ff @(posedge clk)
	begin
		if (filterWrite.en && !(hostWrite.en && hostWrite.addr == filterWrite.addr))
			shadow[filterWrite.addr] <= filterWrite.data;
		if (hostWrite.en)
			shadow[hostWrite.addr] <= hostWrite.data;
		hostExpect <= shadow[hostReadAddr];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			writeCount <= '0;
		end
		else
		begin
			if (start && !running)
			begin
				running <= 1'b1;
				writeCount <= '0;
			end
			else if (done)
				running <= 1'b0;
			if (running && filterWrite.en)
				writeCount <= writeCount + 1'b1;
		end
	end

	// Shift job in flight timed from the cycle ready rises
	always_ff @(posedge clk)
	begin
		if (reset)
			shiftPending <= 1'b0;
		else if (!shiftPending && shiftReq.ready)
		begin
			shiftPending <= 1'b1;
			shiftCycles <= 5'd1;
			shiftTarget <= (shiftReq.count == 4'd0) ? 5'd1 : {1'b0, shiftReq.count};
			shiftExpect <= shlSat(shiftReq.value, shiftReq.count);
		end
		else if (shiftPending)
		begin
			if (shiftResp.done)
				shiftPending <= 1'b0;
			else
				shiftCycles <= shiftCycles + 5'd1;
		end
	end

	////////////////////
	// Assertions
	////////////////////

	goldenWrite: assert property (@(posedge clk) disable iff (reset)
		filterWrite.en |-> filterWrite.data == expectedY)
		else
		begin
			$error("MISMATCH filterWrite.data at %h: got %h, expected %h",
				filterWrite.addr, filterWrite.data, expectedY);
			failCount++;
		end

	writeInRun: assert property (@(posedge clk) disable iff (reset)
		filterWrite.en |-> running)
		else
		begin
			$error("filter write outside a run");
			failCount++;
		end

	doneCount: assert property (@(posedge clk) disable iff (reset)
		done |-> running && writeCount == {1'b0, LG})
		else
		begin
			$error("done after %0d writes, LG is %0d", writeCount, LG);
			failCount++;
		end

	donePulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else
		begin
			$error("done held longer than one cycle");
			failCount++;
		end

	shiftTiming: assert property (@(posedge clk) disable iff (reset)
		shiftResp.done |-> shiftPending && shiftCycles == shiftTarget)
		else
		begin
			$error("shifter done after %0d cycles, expected after %0d cycles",
				shiftCycles, shiftTarget);
			failCount++;
		end

	shiftValue: assert property (@(posedge clk) disable iff (reset)
		shiftResp.done |-> shiftResp.value == shiftExpect)
		else
		begin
			$error("MISMATCH shiftResp.value: got %h, expected %h",
				shiftResp.value, shiftExpect);
			failCount++;
		end

	hostRead: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(hostExpect) |-> hostReadData == hostExpect)
		else
		begin
			$error("MISMATCH hostReadData: got %h, expected %h", hostReadData, hostExpect);
			failCount++;
		end

endmodule

bind residueTop residueProps props (
	.clk(clk),
	.reset(reset),
	.start(start),
	.done(done),
	.A(A),
	.X(X),
	.Y(Y),
	.LG(LG),
	.scaleShift(scaleShift),
	.filterWrite(filterWrite),
	.hostWrite(hostWrite),
	.hostReadAddr(hostReadAddr),
	.hostReadData(hostReadData),
	.shiftReq(shiftReq),
	.shiftResp(shiftResp)
);

//--- test/residueTb.sv
`include "residueParams.svh"

module residueTb;
	import residueMemPkg::*;

	localparam int NUM_RUNS = 5;
	localparam int MAX_LG = 24;
	localparam int MAX_SHIFT = 7;
	localparam int BUDGET_CYCLES = NUM_RUNS * MAX_LG * (40 + MAX_SHIFT) * 2;
	localparam memAddr COEF_BASE = 12'h100;
	localparam memAddr SAMPLE_BASE = 12'h200;
	localparam memAddr OUT_BASE = 12'h300;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic start = 1'b0;
	memAddr A = '0;
	memAddr X = '0;
	memAddr Y = '0;
	logic [`LG_BITS-1:0] LG = '0;
	logic [3:0] scaleShift = '0;
	logic done;
	memWrite hostWrite = '0;
	memAddr hostReadAddr = '0;
	logic [31:0] hostReadData;

	// Every word the host has written
	logic [31:0] model [`MEM_DEPTH];
	int readErrors = 0;
	int totalErrors;

	residueTop dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.A(A),
		.X(X),
		.Y(Y),
		.LG(LG),
		.scaleShift(scaleShift),
		.done(done),
		.hostWrite(hostWrite),
		.hostReadAddr(hostReadAddr),
		.hostReadData(hostReadData)
	);

	always #2 clk = ~clk;

	////////////////////
	// Host port helpers
	////////////////////

	// Sign-extended Q15 word, full range or pinned to the extremes
	function automatic logic [31:0] pickSample(input bit extreme);
		int unsigned r;
		logic [15:0] s;
		r = $urandom;
		if (!extreme)
			s = r[15:0];
		else if (r % 3 == 0)
			s = 16'h7FFF;
		else if (r % 3 == 1)
			s = 16'h8000;
		else
			s = 16'h8001;
		return {{16{s[15]}}, s};
	endfunction

	task automatic hostStore(input memAddr addr, input logic [31:0] data);
		@(posedge clk);
		hostWrite <= '{en: 1'b1, addr: addr, data: data};
		model[addr] = data;
	endtask

	// Data is registered, so it shows up a cycle after the address
	task automatic readBack(input memAddr addr, input bit compare);
		@(posedge clk);
		hostReadAddr <= addr;
		@(posedge clk);
		@(negedge clk);
		if (compare && hostReadData !== model[addr])
		begin
			$display("MISMATCH hostReadData at %h: got %h, expected %h",
				addr, hostReadData, model[addr]);
			readErrors++;
		end
	endtask

	////////////////////
	// One filter run
	////////////////////

	task automatic runFilter(input int lg, input int shift, input bit extreme,
		input bit restart);
		@(posedge clk);
		A <= COEF_BASE;
		X <= SAMPLE_BASE;
		Y <= OUT_BASE;
		LG <= lg[`LG_BITS-1:0];
		scaleShift <= shift[3:0];
		for (int j = 0; j <= 10; j++)
			hostStore(memAddr'(COEF_BASE + j), pickSample(extreme));
		// History starts ten words below X
		for (int i = -10; i < lg; i++)
			hostStore(memAddr'(SAMPLE_BASE + i), pickSample(extreme));
		// Guard words just outside the output block
		hostStore(memAddr'(OUT_BASE - 1), {20'hA5A5A, memAddr'(OUT_BASE - 1)});
		hostStore(memAddr'(OUT_BASE + lg), {20'h5A5A5, memAddr'(OUT_BASE + lg)});
		@(posedge clk);
		hostWrite.en <= 1'b0;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (restart)
		begin
			// Stray start in the middle of a run
			repeat (20) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		do
			@(negedge clk);
		while (!done);
		for (int j = 0; j <= 10; j++)
			readBack(memAddr'(COEF_BASE + j), 1'b1);
		for (int i = -10; i < lg; i++)
			readBack(memAddr'(SAMPLE_BASE + i), 1'b1);
		readBack(memAddr'(OUT_BASE - 1), 1'b1);
		readBack(memAddr'(OUT_BASE + lg), 1'b1);
		// Outputs are checked against the shadow memory in the props
		for (int i = 0; i < lg; i++)
			readBack(memAddr'(OUT_BASE + i), 1'b0);
	endtask

	initial
	begin
		void'($urandom(61103));
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		runFilter(24, 3, 1'b0, 1'b1);
		runFilter(16, 0, 1'b0, 1'b0);
		runFilter(0, 7, 1'b0, 1'b0);
		runFilter(20, 7, 1'b1, 1'b0);
		runFilter(12, 3, 1'b1, 1'b1);
		repeat (4) @(posedge clk);
		totalErrors = readErrors + dut.props.failCount;
		$display("Errors: read-back %0d, assertion %0d", readErrors, dut.props.failCount);
		if (totalErrors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(BUDGET_CYCLES * 4);
		$display("Timeout: the filter runs did not finish within %0d cycles", BUDGET_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- residueTop.f
+incdir+verilog
verilog/basicOpPkg.sv
verilog/residueMemPkg.sv
verilog/basicOps.sv
verilog/longShifter.sv
verilog/sampleMemory.sv
verilog/residueFilter.sv
verilog/residueTop.sv
test/residueProps.sv
test/residueTb.sv
